/* logic/rv_macros.svh */
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// Integer datapath and address width
`define XLEN 32
`define REG_ADDR_W 5

`define MEM_WORDS 256   // Data memory depth in words
`define MEM_CREDITS 2   // Request queue slots, one credit each

`endif

/* logic/rv_pipe_pkg.sv */
package rv_pipe_pkg;

    // Branch condition carried from decode
    typedef enum logic [2:0] {
        br_none = 3'b000,
        br_eq   = 3'b001,
        br_ne   = 3'b010,
        br_lt   = 3'b011,
        br_ge   = 3'b100,
        br_ltu  = 3'b101,
        br_geu  = 3'b110,
        br_jalr = 3'b111   // Always taken
    } branch_cond_t;

    typedef enum logic [1:0] {
        mem_none  = 2'b00,
        mem_store = 2'b01,
        mem_load  = 2'b10
    } mem_op_t;

    // Same values as funct3 of the load opcode
    typedef enum logic [2:0] {
        ld_lb  = 3'b000,
        ld_lh  = 3'b001,
        ld_lw  = 3'b010,
        ld_lbu = 3'b100,
        ld_lhu = 3'b101
    } load_kind_t;

    typedef enum logic [1:0] {
        wb_alu = 2'b00,
        wb_mem = 2'b01,
        wb_pc4 = 2'b10
    } wb_src_t;

endpackage

/* logic/rv_bus_pkg.sv */
package rv_bus_pkg;

    // Width of one data bus access
    typedef enum logic [1:0] {
        size_byte = 2'b00,
        size_half = 2'b01,
        size_word = 2'b10
    } access_size_t;

    // One write enable per byte lane, bit 0 is the lowest lane
    typedef logic [3:0] byte_strobe_t;

    localparam byte_strobe_t strobe_none = 4'b0000;
    localparam byte_strobe_t strobe_word = 4'b1111;
    localparam byte_strobe_t strobe_low_half = 4'b0011;
    localparam byte_strobe_t strobe_high_half = 4'b1100;

endpackage

/* logic/branch_resolve.sv */
`timescale 1ns/1ps
`include "rv_macros.svh"

module branch_resolve
    import rv_pipe_pkg::*;
(
    input  branch_cond_t      br_cond,
    input  logic [`XLEN-1:0]  rs1_data,
    input  logic [`XLEN-1:0]  rs2_data,
    input  logic [`XLEN-1:0]  alu_result,
    input  logic [`XLEN-1:0]  pc_branch,
    output logic              taken,
    output logic [`XLEN-1:0]  target
);

    logic is_eq;
    logic is_ne;
    logic is_lt;
    logic is_ge;
    logic is_ltu;
    logic is_geu;

    assign is_eq  = (rs1_data == rs2_data);
    assign is_ne  = (rs1_data != rs2_data);
    assign is_lt  = ($signed(rs1_data) < $signed(rs2_data));
    assign is_ge  = ($signed(rs1_data) >= $signed(rs2_data));
    assign is_ltu = (rs1_data < rs2_data);   // Plain compare is unsigned
    assign is_geu = (rs1_data >= rs2_data);

    always_comb begin
        unique case (br_cond)
            br_eq:   taken = is_eq;
            br_ne:   taken = is_ne;
            br_lt:   taken = is_lt;
            br_ge:   taken = is_ge;
            br_ltu:  taken = is_ltu;
            br_geu:  taken = is_geu;
            br_jalr: taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    // JALR jumps to rs1 + imm from the ALU
    assign target = (br_cond == br_jalr) ? alu_result : pc_branch;

endmodule

/* logic/load_format.sv */
`timescale 1ns/1ps
`include "rv_macros.svh"

module load_format
    import rv_pipe_pkg::*;
(
    input  load_kind_t        load_kind,
    input  logic [1:0]        byte_offset,
    input  logic [`XLEN-1:0]  rdata,
    output logic [`XLEN-1:0]  value
);

    logic [`XLEN-1:0] shifted;

    // Move the addressed lane down to bit 0
    assign shifted = rdata >> {byte_offset, 3'b000};

    always_comb begin
        unique case (load_kind)
            ld_lb:   value = {{(`XLEN-8){shifted[7]}}, shifted[7:0]};
            ld_lh:   value = {{(`XLEN-16){shifted[15]}}, shifted[15:0]};
            ld_lbu:  value = {{(`XLEN-8){1'b0}}, shifted[7:0]};
            ld_lhu:  value = {{(`XLEN-16){1'b0}}, shifted[15:0]};
            default: value = shifted;   // lw, offset is zero
        endcase
    end

endmodule

/* logic/credit_counter.sv */
`timescale 1ns/1ps
`include "rv_macros.svh"

module credit_counter (
    input  logic clk,
    input  logic rst,
    input  logic spend,
    input  logic give_back,
    output logic credit_avail
);

    localparam int CNT_W = $clog2(`MEM_CREDITS + 1);

    logic [CNT_W-1:0] count;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            count <= CNT_W'(`MEM_CREDITS);   // Queue empty, all credits home
        end else begin
            unique case ({spend, give_back})
                2'b10:   count <= count - 1'b1;
                2'b01:   count <= count + 1'b1;
                default: count <= count;   // Both or neither
            endcase
        end
    end

    assign credit_avail = (count != '0);

    // The stage must only issue with a credit in hand
    assert property (@(posedge clk) disable iff (!rst)
        spend && !give_back |-> count != '0)
        else $error("credit underflow");

    // Memory cannot return more credits than it was given
    assert property (@(posedge clk) disable iff (!rst)
        give_back && !spend |-> count < CNT_W'(`MEM_CREDITS))
        else $error("credit count above queue depth");

endmodule

/* logic/mem_stage_ctrl.sv */
`timescale 1ns/1ps

module mem_stage_ctrl
    import rv_pipe_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    in_valid,
    input  mem_op_t mem_op,
    input  logic    credit_avail,
    input  logic    rsp_valid,
    output logic    in_ready,
    output logic    accept
);

    typedef enum logic {
        st_idle,
        st_load_wait
    } state_t;

    state_t state;
    state_t state_next;
    logic   needs_credit;

    assign needs_credit = (mem_op != mem_none);

    // A memory op waits for a free queue slot
    assign in_ready = (state == st_idle) && !(needs_credit && !credit_avail);
    assign accept   = in_valid && in_ready;

    always_comb begin
        state_next = state;
        unique case (state)
            st_idle: begin
                if (accept && mem_op == mem_load) begin
                    state_next = st_load_wait;
                end
            end
            st_load_wait: begin
                if (rsp_valid) begin
                    state_next = st_idle;   // Writeback goes out next cycle
                end
            end
            default: state_next = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

    // Only a waiting load may receive read data
    assert property (@(posedge clk) disable iff (!rst)
        state == st_idle |-> !rsp_valid)
        else $error("load response with no load outstanding");

endmodule

/* logic/mem_access.sv */
`timescale 1ns/1ps
`include "rv_macros.svh"

module mem_access
    import rv_pipe_pkg::*;
    import rv_bus_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   accept,
    input  branch_cond_t           br_cond,
    input  mem_op_t                mem_op,
    input  load_kind_t             load_kind,
    input  access_size_t           access_size,
    input  wb_src_t                wb_src,
    input  logic                   reg_write,
    input  logic [`REG_ADDR_W-1:0] rd,
    input  logic [`XLEN-1:0]       alu_result,
    input  logic [`XLEN-1:0]       pc_plus4,
    input  logic [`XLEN-1:0]       pc_branch,
    input  logic [`XLEN-1:0]       rs1_data,
    input  logic [`XLEN-1:0]       rs2_data,
    input  logic                   rsp_valid,
    input  logic [`XLEN-1:0]       rsp_rdata,
    output logic                   req_valid,
    output logic                   req_write,
    output logic [`XLEN-1:0]       req_addr,
    output logic [`XLEN-1:0]       req_wdata,
    output byte_strobe_t           req_strobe,
    output logic                   branch_taken,
    output logic [`XLEN-1:0]       branch_target,
    output logic                   wb_valid,
    output logic                   wb_reg_write,
    output logic [`REG_ADDR_W-1:0] wb_rd,
    output logic [`XLEN-1:0]       wb_data
);

    logic                   br_taken_raw;
    logic [`XLEN-1:0]       direct_data;
    logic [`XLEN-1:0]       load_value;
    logic                   pend_reg_write;
    logic [`REG_ADDR_W-1:0] pend_rd;
    wb_src_t                pend_src;
    logic [`XLEN-1:0]       pend_data;
    load_kind_t             pend_kind;
    logic [1:0]             pend_offset;

    branch_resolve u_branch (
        .br_cond    (br_cond),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .alu_result (alu_result),
        .pc_branch  (pc_branch),
        .taken      (br_taken_raw),
        .target     (branch_target)
    );

    assign branch_taken = accept && br_taken_raw;   // Only meaningful on accept

    assign req_valid = accept && (mem_op != mem_none);
    assign req_write = (mem_op == mem_store);
    assign req_addr  = alu_result;

    // Store data goes out on every lane, the strobe picks the lanes
    always_comb begin
        unique case (access_size)
            size_byte: begin
                req_wdata  = {(`XLEN/8){rs2_data[7:0]}};
                req_strobe = byte_strobe_t'(4'b0001 << alu_result[1:0]);
            end
            size_half: begin
                req_wdata  = {(`XLEN/16){rs2_data[15:0]}};
                req_strobe = alu_result[1] ? strobe_high_half : strobe_low_half;
            end
            size_word: begin
                req_wdata  = rs2_data;
                req_strobe = strobe_word;
            end
            default: begin
                req_wdata  = rs2_data;
                req_strobe = strobe_none;
            end
        endcase
    end

    assign direct_data = (wb_src == wb_pc4) ? pc_plus4 : alu_result;

    load_format u_format (
        .load_kind   (pend_kind),
        .byte_offset (pend_offset),
        .rdata       (rsp_rdata),
        .value       (load_value)
    );

    // Load fields parked until the response arrives
    always_ff @(posedge clk) begin
        if (accept && mem_op == mem_load) begin
            pend_reg_write <= reg_write;
            pend_rd        <= rd;
            pend_src       <= wb_src;
            pend_data      <= direct_data;
            pend_kind      <= load_kind;
            pend_offset    <= alu_result[1:0];
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            wb_valid     <= 1'b0;
            wb_reg_write <= 1'b0;
        end else begin
            wb_valid <= 1'b0;
            if (accept && mem_op != mem_load) begin
                wb_valid     <= 1'b1;
                wb_reg_write <= reg_write && (mem_op != mem_store);   // Stores never write rd
            end else if (rsp_valid) begin
                wb_valid     <= 1'b1;
                wb_reg_write <= pend_reg_write;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept && mem_op != mem_load) begin
            wb_rd   <= rd;
            wb_data <= direct_data;
        end else if (rsp_valid) begin
            wb_rd   <= pend_rd;
            wb_data <= (pend_src == wb_mem) ? load_value : pend_data;
        end
    end

endmodule

/* logic/data_mem.sv */
`timescale 1ns/1ps
`include "rv_macros.svh"

module data_mem
    import rv_bus_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic             mem_hold,
    input  logic             req_valid,
    input  logic             req_write,
    input  logic [`XLEN-1:0] req_addr,
    input  logic [`XLEN-1:0] req_wdata,
    input  byte_strobe_t     req_strobe,
    output logic             rsp_valid,
    output logic [`XLEN-1:0] rsp_rdata,
    output logic             credit_return
);

    localparam int DEPTH = `MEM_CREDITS;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam int IDX_W = $clog2(`MEM_WORDS);

    logic [`XLEN-1:0] mem [`MEM_WORDS];

    logic             q_write  [DEPTH];
    logic [IDX_W-1:0] q_idx    [DEPTH];
    logic [`XLEN-1:0] q_wdata  [DEPTH];
    byte_strobe_t     q_strobe [DEPTH];

    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [CNT_W-1:0] count;
    logic             pop;

    // Head leaves the cycle after it was pushed unless held
    assign pop           = (count != '0) && !mem_hold;
    assign credit_return = pop;
    assign rsp_valid     = pop && !q_write[head];
    assign rsp_rdata     = mem[q_idx[head]];

    always_ff @(posedge clk) begin
        if (req_valid) begin
            q_write[tail]  <= req_write;
            q_idx[tail]    <= req_addr[IDX_W+1:2];   // Word index, low bits are lane
            q_wdata[tail]  <= req_wdata;
            q_strobe[tail] <= req_strobe;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (req_valid) begin
                tail <= (tail == PTR_W'(DEPTH - 1)) ? '0 : tail + 1'b1;
            end
            if (pop) begin
                head <= (head == PTR_W'(DEPTH - 1)) ? '0 : head + 1'b1;
            end
            count <= count + CNT_W'(req_valid) - CNT_W'(pop);
        end
    end

    // Strobed write on a store pop
    always_ff @(posedge clk) begin
        if (pop && q_write[head]) begin
            for (int i = 0; i < `XLEN/8; i++) begin
                if (q_strobe[head][i]) begin
                    mem[q_idx[head]][8*i +: 8] <= q_wdata[head][8*i +: 8];
                end
            end
        end
    end

    // Credits upstream must keep the queue from overflowing
    assert property (@(posedge clk) disable iff (!rst)
        req_valid |-> count < CNT_W'(DEPTH))
        else $error("request pushed into a full queue");

endmodule

/* logic/mem_access_top.sv */
`timescale 1ns/1ps
`include "rv_macros.svh"

module mem_access_top
    import rv_pipe_pkg::*;
    import rv_bus_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   mem_hold,
    input  logic                   in_valid,
    output logic                   in_ready,
    input  branch_cond_t           br_cond,
    input  mem_op_t                mem_op,
    input  load_kind_t             load_kind,
    input  access_size_t           access_size,
    input  wb_src_t                wb_src,
    input  logic                   reg_write,
    input  logic [`REG_ADDR_W-1:0] rd,
    input  logic [`XLEN-1:0]       alu_result,
    input  logic [`XLEN-1:0]       pc_plus4,
    input  logic [`XLEN-1:0]       pc_branch,
    input  logic [`XLEN-1:0]       rs1_data,
    input  logic [`XLEN-1:0]       rs2_data,
    output logic                   branch_taken,
    output logic [`XLEN-1:0]       branch_target,
    output logic                   wb_valid,
    output logic                   wb_reg_write,
    output logic [`REG_ADDR_W-1:0] wb_rd,
    output logic [`XLEN-1:0]       wb_data
);

    logic             accept;
    logic             credit_avail;
    logic             req_valid;
    logic             req_write;
    logic [`XLEN-1:0] req_addr;
    logic [`XLEN-1:0] req_wdata;
    byte_strobe_t     req_strobe;
    logic             rsp_valid;
    logic [`XLEN-1:0] rsp_rdata;
    logic             credit_return;

    mem_stage_ctrl u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .in_valid     (in_valid),
        .mem_op       (mem_op),
        .credit_avail (credit_avail),
        .rsp_valid    (rsp_valid),
        .in_ready     (in_ready),
        .accept       (accept)
    );

    credit_counter u_credits (
        .clk          (clk),
        .rst          (rst),
        .spend        (req_valid),       // One credit per request
        .give_back    (credit_return),
        .credit_avail (credit_avail)
    );

    mem_access u_stage (
        .clk           (clk),
        .rst           (rst),
        .accept        (accept),
        .br_cond       (br_cond),
        .mem_op        (mem_op),
        .load_kind     (load_kind),
        .access_size   (access_size),
        .wb_src        (wb_src),
        .reg_write     (reg_write),
        .rd            (rd),
        .alu_result    (alu_result),
        .pc_plus4      (pc_plus4),
        .pc_branch     (pc_branch),
        .rs1_data      (rs1_data),
        .rs2_data      (rs2_data),
        .rsp_valid     (rsp_valid),
        .rsp_rdata     (rsp_rdata),
        .req_valid     (req_valid),
        .req_write     (req_write),
        .req_addr      (req_addr),
        .req_wdata     (req_wdata),
        .req_strobe    (req_strobe),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .wb_valid      (wb_valid),
        .wb_reg_write  (wb_reg_write),
        .wb_rd         (wb_rd),
        .wb_data       (wb_data)
    );

    data_mem u_dmem (
        .clk           (clk),
        .rst           (rst),
        .mem_hold      (mem_hold),
        .req_valid     (req_valid),
        .req_write     (req_write),
        .req_addr      (req_addr),
        .req_wdata     (req_wdata),
        .req_strobe    (req_strobe),
        .rsp_valid     (rsp_valid),
        .rsp_rdata     (rsp_rdata),
        .credit_return (credit_return)
    );

endmodule

/* testbench/tb_mem_access.sv */
`timescale 1ns/1ps
`include "rv_macros.svh"

module tb_mem_access
    import rv_pipe_pkg::*;
    import rv_bus_pkg::*;
();

    localparam int          IDX_W         = $clog2(`MEM_WORDS);
    localparam int          READY_TIMEOUT = 200;
    localparam int          DRAIN_TIMEOUT = 400;
    localparam logic [31:0] LFSR_TAPS     = 32'h8020_0003;   // x^32 + x^22 + x^2 + x + 1

    typedef struct packed {
        logic                   reg_write;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       data;
        logic                   taken;
        logic [`XLEN-1:0]       target;
        logic                   check_target;
        logic                   timed;       // Non-load, writeback one cycle after accept
        logic [31:0]            wb_cycle;
    } wb_entry_t;

    typedef struct packed {
        logic             taken;
        logic [`XLEN-1:0] target;
    } branch_obs_t;

    logic                   clk;
    logic                   rst;
    logic                   mem_hold;
    logic                   in_valid;
    logic                   in_ready;
    branch_cond_t           br_cond;
    mem_op_t                mem_op;
    load_kind_t             load_kind;
    access_size_t           access_size;
    wb_src_t                wb_src;
    logic                   reg_write;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`XLEN-1:0]       alu_result;
    logic [`XLEN-1:0]       pc_plus4;
    logic [`XLEN-1:0]       pc_branch;
    logic [`XLEN-1:0]       rs1_data;
    logic [`XLEN-1:0]       rs2_data;
    logic                   branch_taken;
    logic [`XLEN-1:0]       branch_target;
    logic                   wb_valid;
    logic                   wb_reg_write;
    logic [`REG_ADDR_W-1:0] wb_rd;
    logic [`XLEN-1:0]       wb_data;

    logic [`XLEN-1:0] shadow_mem [`MEM_WORDS];   // Word image as the program sees it
    wb_entry_t        exp_q [$];
    branch_obs_t      obs_q [$];
    wb_entry_t        head_exp;
    branch_obs_t      head_obs;
    logic [31:0]      lfsr_state  = 32'd2074;
    int               cyc         = 0;
    bit               hold_random = 1'b0;
    bit               saw_stall   = 1'b0;

    mem_access_top dut (
        .clk           (clk),
        .rst           (rst),
        .mem_hold      (mem_hold),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .br_cond       (br_cond),
        .mem_op        (mem_op),
        .load_kind     (load_kind),
        .access_size   (access_size),
        .wb_src        (wb_src),
        .reg_write     (reg_write),
        .rd            (rd),
        .alu_result    (alu_result),
        .pc_plus4      (pc_plus4),
        .pc_branch     (pc_branch),
        .rs1_data      (rs1_data),
        .rs2_data      (rs2_data),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .wb_valid      (wb_valid),
        .wb_reg_write  (wb_reg_write),
        .wb_rd         (wb_rd),
        .wb_data       (wb_data)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    function automatic logic next_bit();
        logic out;
        out = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out) begin
            lfsr_state = lfsr_state ^ LFSR_TAPS;
        end
        return out;
    endfunction

    function automatic logic [31:0] next_bits(int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits = {bits[30:0], next_bit()};
        end
        return bits;
    endfunction

    function automatic logic branch_rule(branch_cond_t bc, logic [31:0] a, logic [31:0] b);
        case (bc)
            br_eq:   return a == b;
            br_ne:   return a != b;
            br_lt:   return $signed(a) < $signed(b);
            br_ge:   return !($signed(a) < $signed(b));
            br_ltu:  return a < b;
            br_geu:  return !(a < b);
            br_jalr: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic [31:0] load_rule(load_kind_t lk, logic [31:0] word,
                                              logic [1:0] off);
        logic [7:0]  b;
        logic [15:0] h;
        b = 8'(word >> (8 * off));
        h = off[1] ? word[31:16] : word[15:0];
        case (lk)
            ld_lb:   return {{24{b[7]}}, b};
            ld_lh:   return {{16{h[15]}}, h};
            ld_lbu:  return {24'h0, b};
            ld_lhu:  return {16'h0, h};
            default: return word;
        endcase
    endfunction

    // Expected writeback and branch result of one accepted instruction
    function automatic void model_exec(branch_cond_t bc, mem_op_t op, load_kind_t lk,
            access_size_t sz, wb_src_t src, logic rw, logic [4:0] dst, logic [31:0] alu,
            logic [31:0] pc4, logic [31:0] pcb, logic [31:0] a, logic [31:0] b,
            int acc_cyc);
        wb_entry_t        e;
        logic [IDX_W-1:0] idx;
        logic [1:0]       off;
        idx            = alu[IDX_W+1:2];
        off            = alu[1:0];
        e.rd           = dst;
        e.reg_write    = rw && (op != mem_store);
        e.data         = (src == wb_pc4) ? pc4 : alu;
        e.taken        = branch_rule(bc, a, b);
        e.target       = (bc == br_jalr) ? alu : pcb;
        e.check_target = (bc != br_none);
        e.timed        = (op != mem_load);
        e.wb_cycle     = 32'(acc_cyc + 1);
        if (op == mem_store) begin
            case (sz)
                size_byte: shadow_mem[idx][8*off +: 8] = b[7:0];
                size_half: shadow_mem[idx][8*off +: 16] = b[15:0];
                default:   shadow_mem[idx] = b;
            endcase
        end else if (op == mem_load && src == wb_mem) begin
            e.data = load_rule(lk, shadow_mem[idx], off);
        end
        exp_q.push_back(e);
    endfunction

    task automatic stop_with_fail(string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic expect_equal(string name, logic [31:0] got, logic [31:0] exp);
        assert (got === exp)
            else stop_with_fail($sformatf("Fail: %s got %h expected %h", name, got, exp));
    endtask

    // Next drive point, 1 ns after the rising edge
    task automatic tick();
        @(posedge clk);
        #1;
        if (hold_random) begin
            mem_hold = next_bit();
        end
    endtask

    task automatic send_instr(branch_cond_t bc, mem_op_t op, load_kind_t lk,
            access_size_t sz, wb_src_t src, logic rw, logic [4:0] dst, logic [31:0] alu,
            logic [31:0] pc4, logic [31:0] pcb, logic [31:0] a, logic [31:0] b);
        int          waited;
        branch_obs_t obs;
        br_cond     = bc;
        mem_op      = op;
        load_kind   = lk;
        access_size = sz;
        wb_src      = src;
        reg_write   = rw;
        rd          = dst;
        alu_result  = alu;
        pc_plus4    = pc4;
        pc_branch   = pcb;
        rs1_data    = a;
        rs2_data    = b;
        in_valid    = 1'b1;
        waited      = 0;
        @(negedge clk);
        while (!in_ready) begin
            if (op != mem_none) begin
                saw_stall = 1'b1;
            end
            assert (waited < READY_TIMEOUT)
                else stop_with_fail("Timed out waiting for in_ready");
            waited++;
            tick();
            @(negedge clk);
        end
        obs.taken  = branch_taken;   // Only valid on the accept cycle
        obs.target = branch_target;
        obs_q.push_back(obs);
        model_exec(bc, op, lk, sz, src, rw, dst, alu, pc4, pcb, a, b, cyc);
        tick();
        in_valid = 1'b0;
    endtask

    task automatic alu_op(wb_src_t src, logic rw, logic [4:0] dst, logic [31:0] alu,
                          logic [31:0] pc4);
        send_instr(br_none, mem_none, ld_lw, size_word, src, rw, dst, alu, pc4,
                   32'h0, 32'h0, 32'h0);
    endtask

    task automatic store_op(access_size_t sz, logic [31:0] addr, logic [31:0] data);
        send_instr(br_none, mem_store, ld_lw, sz, wb_alu, next_bit(), 5'(next_bits(5)),
                   addr, 32'h0, 32'h0, 32'h0, data);
    endtask

    task automatic load_op(load_kind_t lk, logic [31:0] addr);
        send_instr(br_none, mem_load, lk, size_word, wb_mem, 1'b1, 5'(next_bits(5)),
                   addr, 32'h0, 32'h0, 32'h0, 32'h0);
    endtask

    // Stores and loads sharing the lanes of one random word
    task automatic lane_test();
        logic [31:0] base;
        logic [1:0]  off;
        logic [1:0]  hoff;
        base = next_bits(IDX_W) << 2;
        off  = 2'(next_bits(2));
        hoff = {next_bit(), 1'b0};
        store_op(size_word, base, next_bits(32));
        store_op(size_byte, base + 32'(off), next_bits(32));
        load_op(ld_lb, base + 32'(off));
        load_op(ld_lbu, base + 32'(off));
        store_op(size_half, base + 32'(hoff), next_bits(32));
        load_op(ld_lh, base + 32'(hoff));
        load_op(ld_lhu, base + 32'(hoff));
        load_op(ld_lw, base);
    endtask

    task automatic check_idle_outputs();
        expect_equal("wb_valid", 32'(wb_valid), 32'h0);
        expect_equal("branch_taken", 32'(branch_taken), 32'h0);
        expect_equal("in_ready", 32'(in_ready), 32'h1);
    endtask

    always @(negedge clk) begin
        if (rst && wb_valid) begin
            assert (exp_q.size() != 0 && obs_q.size() != 0)
                else stop_with_fail("Writeback arrived with no instruction outstanding");
            head_exp = exp_q.pop_front();
            head_obs = obs_q.pop_front();
            expect_equal("wb_reg_write", 32'(wb_reg_write), 32'(head_exp.reg_write));
            expect_equal("wb_rd", 32'(wb_rd), 32'(head_exp.rd));
            if (head_exp.reg_write) begin
                expect_equal("wb_data", wb_data, head_exp.data);
            end
            expect_equal("branch_taken", 32'(head_obs.taken), 32'(head_exp.taken));
            if (head_exp.check_target) begin
                expect_equal("branch_target", head_obs.target, head_exp.target);
            end
            if (head_exp.timed) begin
                assert (cyc == head_exp.wb_cycle)
                    else stop_with_fail("Writeback did not come one cycle after accept");
            end
        end
    end

    initial begin
        logic [31:0]  a;
        logic [31:0]  b;
        logic [1:0]   mode;
        logic [31:0]  bp_addr [6];
        int           waited;
        branch_cond_t bc;
        rst         = 1'b0;
        mem_hold    = 1'b0;
        in_valid    = 1'b0;
        br_cond     = br_jalr;   // Raw taken high with in_valid low
        mem_op      = mem_none;
        load_kind   = ld_lw;
        access_size = size_word;
        wb_src      = wb_alu;
        reg_write   = 1'b0;
        rd          = '0;
        alu_result  = '0;
        pc_plus4    = '0;
        pc_branch   = '0;
        rs1_data    = '0;
        rs2_data    = '0;

        repeat (4) begin
            @(posedge clk);
            @(negedge clk);
            check_idle_outputs();
        end
        tick();
        rst = 1'b1;
        repeat (2) begin
            @(negedge clk);
            check_idle_outputs();
        end
        tick();

        repeat (16) begin
            a = next_bits(32);
            b = next_bits(32);
            alu_op(next_bit() ? wb_pc4 : wb_alu, next_bit(), 5'(next_bits(5)), a, b);
        end

        for (int c = 0; c < 8; c++) begin
            bc = branch_cond_t'(c[2:0]);
            repeat (8) begin
                a    = next_bits(32);
                mode = 2'(next_bits(2));
                case (mode)
                    2'd0:    b = a;
                    2'd1:    b = a ^ 32'h8000_0000;   // Signed and unsigned disagree
                    default: b = next_bits(32);
                endcase
                send_instr(bc, mem_none, ld_lw, size_word,
                           (bc == br_jalr) ? wb_pc4 : wb_alu, bc == br_jalr,
                           5'(next_bits(5)), next_bits(32), next_bits(32), next_bits(32),
                           a, b);
            end
        end

        repeat (12) lane_test();

        hold_random = 1'b1;
        saw_stall   = 1'b0;
        for (int k = 0; k < 6; k++) begin
            bp_addr[k] = next_bits(IDX_W) << 2;
            store_op(size_word, bp_addr[k], next_bits(32));
        end
        for (int k = 0; k < 6; k++) begin
            store_op(size_byte, bp_addr[k] + 32'(next_bits(2)), next_bits(32));
        end
        for (int k = 0; k < 6; k++) begin
            load_op(ld_lw, bp_addr[k]);
            alu_op(wb_alu, 1'b1, 5'(next_bits(5)), next_bits(32), 32'h0);
        end
        assert (saw_stall)
            else stop_with_fail("in_ready never dropped while credits were short");
        hold_random = 1'b0;
        mem_hold    = 1'b0;

        waited = 0;
        while (exp_q.size() != 0 && waited < DRAIN_TIMEOUT) begin
            tick();
            waited++;
        end
        repeat (4) tick();   // Catch any extra writeback
        if (exp_q.size() == 0) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            stop_with_fail("Writebacks still missing at the end of the run");
        end
    end

endmodule

/* files.f */
+incdir+logic
logic/rv_pipe_pkg.sv
logic/rv_bus_pkg.sv
logic/branch_resolve.sv
logic/load_format.sv
logic/credit_counter.sv
logic/mem_stage_ctrl.sv
logic/mem_access.sv
logic/data_mem.sv
logic/mem_access_top.sv
testbench/tb_mem_access.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_mem_access -f files.f -o sim_mem_access
./obj_dir/sim_mem_access > sim.log 2>&1 || true
cat sim.log
if grep -q "^Simulation finished: PASS$" sim.log; then
    echo "Run passed"
else
    echo "Run failed"
    exit 1
fi
